// ==== Makefile ====
TOP = tb_player_input

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f player_input_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== logic/config_defs_pkg.sv ====
/*
 * Configuration definitions
 * Host menu status bit map, download indexes and rotary speed codes
 */

package config_defs_pkg;

	// Rotary speed menu choice, encoding follows menu order
	typedef enum logic [1:0] {
		speed_normal    = 2'd0,
		speed_slow      = 2'd1,
		speed_fast      = 2'd2,
		speed_very_fast = 2'd3
	} rot_speed_t;

	// =====================================================================
	// Status word bit positions
	// =====================================================================
	// DB15 select per player
	localparam int stat_src_p1    = 20;
	localparam int stat_src_p2    = 21;
	// Keystroke rotation mode
	localparam int stat_kbd_mode  = 24;
	// Low bit of the 2-bit speed field
	localparam int stat_rot_speed = 29;

	// Download stream indexes
	localparam logic [7:0] dl_index_dip  = 8'd254;
	localparam logic [7:0] dl_index_game = 8'd1;

	// DIP switch and game select byte
	typedef logic [7:0] dip_byte_t;

endpackage

// ==== logic/control_mapper.sv ====
/*
 * Control mapper
 * Builds one game core player word from USB or DB15 controls plus dial
 */

`timescale 1ns/1ps

module control_mapper (
	input  input_defs_pkg::ctrl_source_t source,
	input  logic [15:0]                  joystick,
	input  logic [15:0]                  db15,
	input  input_defs_pkg::dial_pos_t    rot_pos,
	output input_defs_pkg::player_word_t player,
	output logic                         rot_left_req,
	output logic                         rot_right_req
);

	// Active low controls
	logic up_n;
	logic down_n;
	logic left_n;
	logic right_n;
	logic shot_n;
	logic grenade_n;
	logic start_n;
	logic coin_n;
	logic service_n;

	// =====================================================================
	// Source select
	// =====================================================================
	always_comb begin
		if (source == input_defs_pkg::src_db15) begin
			// Directions in the low nibble, R L D U order
			up_n          = ~db15[3];
			down_n        = ~db15[2];
			left_n        = ~db15[1];
			right_n       = ~db15[0];
			// B shoots, C throws
			shot_n        = ~db15[5];
			grenade_n     = ~db15[6];
			start_n       = ~db15[10];
			coin_n        = ~db15[11];
			// Select plus B gives service
			service_n     = ~(db15[5] & db15[11]);
			// A and D rotate
			rot_left_req  = db15[4];
			rot_right_req = db15[7];
		end else begin
			up_n          = ~joystick[3];
			down_n        = ~joystick[2];
			left_n        = ~joystick[1];
			right_n       = ~joystick[0];
			shot_n        = ~joystick[4];
			grenade_n     = ~joystick[5];
			start_n       = ~joystick[6];
			coin_n        = ~joystick[7];
			service_n     = ~joystick[10];
			// Shoulder buttons rotate
			rot_left_req  = joystick[8];
			rot_right_req = joystick[9];
		end
	end

	// =====================================================================
	// Word assembly
	// =====================================================================
	always_comb begin
		player = '0;
		// Unused lines tied high
		player[input_defs_pkg::pw_one_hi]  = 1'b1;
		player[input_defs_pkg::pw_one_mid] = 1'b1;
		player[input_defs_pkg::pw_one_lo]  = 1'b1;
		player[input_defs_pkg::pw_up]      = up_n;
		player[input_defs_pkg::pw_down]    = down_n;
		player[input_defs_pkg::pw_right]   = right_n;
		player[input_defs_pkg::pw_left]    = left_n;
		player[input_defs_pkg::pw_service] = service_n;
		// Aim dial straight from the counter
		player[input_defs_pkg::pw_dial_msb:input_defs_pkg::pw_dial_lsb] = rot_pos;
		player[input_defs_pkg::pw_grenade] = grenade_n;
		player[input_defs_pkg::pw_shot]    = shot_n;
		player[input_defs_pkg::pw_start]   = start_n;
		player[input_defs_pkg::pw_coin]    = coin_n;
	end

endmodule

// ==== logic/input_config_regs.sv ====
/*
 * Input configuration registers
 * Decodes host menu status into settings and captures DIP and game
 * bytes from the download stream
 */

`timescale 1ns/1ps

module input_config_regs (
	input  logic                        clk_53p6,
	input  logic                        reset,
	input  logic [31:0]                 status,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [24:0]                 ioctl_addr,
	input  config_defs_pkg::dip_byte_t  ioctl_dout,
	output input_defs_pkg::ctrl_source_t src_p1,
	output input_defs_pkg::ctrl_source_t src_p2,
	output logic                        kbd_mode,
	output config_defs_pkg::rot_speed_t rot_speed,
	output config_defs_pkg::dip_byte_t  dsw1,
	output config_defs_pkg::dip_byte_t  dsw2,
	output config_defs_pkg::dip_byte_t  game_id
);

	// Download write decode
	logic dip_wr;
	logic game_wr;

	// =====================================================================
	// Menu settings
	// =====================================================================
	// Resampled every cycle, one cycle behind status
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			src_p1    <= input_defs_pkg::src_usb;
			src_p2    <= input_defs_pkg::src_usb;
			kbd_mode  <= 1'b0;
			rot_speed <= config_defs_pkg::speed_normal;
		end else begin
			src_p1    <= input_defs_pkg::ctrl_source_t'(status[config_defs_pkg::stat_src_p1]);
			src_p2    <= input_defs_pkg::ctrl_source_t'(status[config_defs_pkg::stat_src_p2]);
			kbd_mode  <= status[config_defs_pkg::stat_kbd_mode];
			// Two bit speed field
			rot_speed <= config_defs_pkg::rot_speed_t'(
				status[config_defs_pkg::stat_rot_speed +: $bits(config_defs_pkg::rot_speed_t)]);
		end
	end

	// =====================================================================
	// DIP switches and game select
	// =====================================================================
	assign dip_wr  = ioctl_wr && (ioctl_index == config_defs_pkg::dl_index_dip);
	assign game_wr = ioctl_wr && (ioctl_index == config_defs_pkg::dl_index_game);

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			// All switches off until the host sends them
			dsw1    <= 8'hFF;
			dsw2    <= 8'hFF;
			game_id <= 8'h00;
		end else begin
			// Only the first two DIP bytes are kept
			if (dip_wr && (ioctl_addr == 25'd0)) begin
				dsw1 <= ioctl_dout;
			end
			if (dip_wr && (ioctl_addr == 25'd1)) begin
				dsw2 <= ioctl_dout;
			end
			// Game byte sits at offset 0
			if (game_wr && (ioctl_addr == 25'd0)) begin
				game_id <= ioctl_dout;
			end
		end
	end

	// Speed select feeds the dial step decode, must stay known
	a_rot_speed_known: assert property (
		@(posedge clk_53p6) disable iff (reset)
		!$isunknown(rot_speed)
	) else $error("rot_speed unknown after reset");

endmodule

// ==== logic/input_defs_pkg.sv ====
/*
 * Player input definitions
 * Player word layout, control source select, dial range and rotate key codes
 */

package input_defs_pkg;

	// Which controller feeds a player
	typedef enum logic {
		src_usb  = 1'b0,
		src_db15 = 1'b1
	} ctrl_source_t;

	// Game core player word, control bits active low
	typedef logic [15:0] player_word_t;

	// =====================================================================
	// Player word bit positions
	// =====================================================================
	localparam int pw_one_hi   = 15;
	localparam int pw_one_mid  = 14;
	localparam int pw_up       = 13;
	localparam int pw_down     = 12;
	localparam int pw_right    = 11;
	localparam int pw_left     = 10;
	localparam int pw_service  = 9;
	localparam int pw_one_lo   = 8;
	// Dial position field, 4 bits
	localparam int pw_dial_msb = 7;
	localparam int pw_dial_lsb = 4;
	localparam int pw_grenade  = 3;
	localparam int pw_shot     = 2;
	localparam int pw_start    = 1;
	localparam int pw_coin     = 0;

	// 12 position aim dial, 0 to 11
	typedef logic [3:0] dial_pos_t;

	localparam dial_pos_t dial_last_pos  = 4'd11;
	localparam dial_pos_t dial_reset_pos = 4'd11;

	// =====================================================================
	// Keyboard scan codes for rotation
	// =====================================================================
	localparam logic [7:0] key_p1_left  = 8'h6B;
	localparam logic [7:0] key_p1_right = 8'h74;
	// C and V keys for player 2
	localparam logic [7:0] key_p2_left  = 8'h21;
	localparam logic [7:0] key_p2_right = 8'h2A;

endpackage

// ==== logic/player_input_top.sv ====
/*
 * Player input top level
 * Config registers, key decoder, dial and two control mappers
 */

`timescale 1ns/1ps

module player_input_top #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic                         clk_53p6,
	input  logic                         reset,
	input  logic [31:0]                  status,
	input  logic [10:0]                  ps2_key,
	input  logic [15:0]                  joystick_0,
	input  logic [15:0]                  joystick_1,
	input  logic [15:0]                  db15_1,
	input  logic [15:0]                  db15_2,
	input  logic                         ioctl_wr,
	input  logic [7:0]                   ioctl_index,
	input  logic [24:0]                  ioctl_addr,
	input  config_defs_pkg::dip_byte_t   ioctl_dout,
	output input_defs_pkg::player_word_t player1,
	output input_defs_pkg::player_word_t player2,
	output config_defs_pkg::dip_byte_t   dsw1,
	output config_defs_pkg::dip_byte_t   dsw2,
	output config_defs_pkg::dip_byte_t   game_id
);

	// Settings
	input_defs_pkg::ctrl_source_t src_p1;
	input_defs_pkg::ctrl_source_t src_p2;
	logic                         kbd_mode;
	config_defs_pkg::rot_speed_t  rot_speed;
	// Keyboard rotate flags
	logic key_left_1;
	logic key_right_1;
	logic key_left_2;
	logic key_right_2;
	// Pad rotate requests
	logic left_req_1;
	logic right_req_1;
	logic left_req_2;
	logic right_req_2;
	// Dial positions
	input_defs_pkg::dial_pos_t pos_1;
	input_defs_pkg::dial_pos_t pos_2;

	input_config_regs config_i (
		.clk_53p6    (clk_53p6),
		.reset       (reset),
		.status      (status),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.src_p1      (src_p1),
		.src_p2      (src_p2),
		.kbd_mode    (kbd_mode),
		.rot_speed   (rot_speed),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game_id     (game_id)
	);

	rotary_key_decoder keys_i (
		.clk_53p6 (clk_53p6),
		.reset    (reset),
		.ps2_key  (ps2_key),
		.kbd_mode (kbd_mode),
		.left_1   (key_left_1),
		.right_1  (key_right_1),
		.left_2   (key_left_2),
		.right_2  (key_right_2)
	);

	rotary_dial #(
		.ROT_DIV_BITS (ROT_DIV_BITS)
	) dial_i (
		.clk_53p6    (clk_53p6),
		.reset       (reset),
		.rot_speed   (rot_speed),
		.kbd_mode    (kbd_mode),
		.left_req_1  (left_req_1),
		.right_req_1 (right_req_1),
		.left_req_2  (left_req_2),
		.right_req_2 (right_req_2),
		.key_left_1  (key_left_1),
		.key_right_1 (key_right_1),
		.key_left_2  (key_left_2),
		.key_right_2 (key_right_2),
		.pos_1       (pos_1),
		.pos_2       (pos_2)
	);

	// Player 1
	control_mapper mapper_1_i (
		.source        (src_p1),
		.joystick      (joystick_0),
		.db15          (db15_1),
		.rot_pos       (pos_1),
		.player        (player1),
		.rot_left_req  (left_req_1),
		.rot_right_req (right_req_1)
	);

	// Player 2
	control_mapper mapper_2_i (
		.source        (src_p2),
		.joystick      (joystick_1),
		.db15          (db15_2),
		.rot_pos       (pos_2),
		.player        (player2),
		.rot_left_req  (left_req_2),
		.rot_right_req (right_req_2)
	);

endmodule

// ==== logic/rotary_dial.sv ====
/*
 * Rotary dial
 * Shared step divider and two 12 position aim dial counters
 */

`timescale 1ns/1ps

module rotary_dial #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic                        clk_53p6,
	input  logic                        reset,
	input  config_defs_pkg::rot_speed_t rot_speed,
	input  logic                        kbd_mode,
	input  logic                        left_req_1,
	input  logic                        right_req_1,
	input  logic                        left_req_2,
	input  logic                        right_req_2,
	input  logic                        key_left_1,
	input  logic                        key_right_1,
	input  logic                        key_left_2,
	input  logic                        key_right_2,
	output input_defs_pkg::dial_pos_t   pos_1,
	output input_defs_pkg::dial_pos_t   pos_2
);

	// Free running step divider
	logic [ROT_DIV_BITS-1:0] div_cnt;
	logic                    step_en;

	// Next dial value, left has priority
	function automatic input_defs_pkg::dial_pos_t next_pos(
		input input_defs_pkg::dial_pos_t pos,
		input logic                      left,
		input logic                      right
	);
		input_defs_pkg::dial_pos_t res;
		res = pos;
		if (left) begin
			// Up with wrap 11 to 0
			res = (pos == input_defs_pkg::dial_last_pos) ? 4'd0 : pos + 4'd1;
		end else if (right) begin
			// Down with wrap 0 to 11
			res = (pos == 4'd0) ? input_defs_pkg::dial_last_pos : pos - 4'd1;
		end
		return res;
	endfunction

	// =====================================================================
	// Step rate
	// =====================================================================
	// Fewer low bits checked means more frequent steps
	always_comb begin
		if (kbd_mode) begin
			// Keystroke mode always runs fastest
			step_en = (div_cnt[ROT_DIV_BITS-4:0] == '0);
		end else begin
			case (rot_speed)
				config_defs_pkg::speed_slow:      step_en = (div_cnt == '0);
				config_defs_pkg::speed_normal:    step_en = (div_cnt[ROT_DIV_BITS-2:0] == '0);
				config_defs_pkg::speed_fast:      step_en = (div_cnt[ROT_DIV_BITS-3:0] == '0);
				config_defs_pkg::speed_very_fast: step_en = (div_cnt[ROT_DIV_BITS-4:0] == '0);
				default:                          step_en = 1'b0;
			endcase
		end
	end

	// =====================================================================
	// Divider and dial counters
	// =====================================================================
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			div_cnt <= '0;
			pos_1   <= input_defs_pkg::dial_reset_pos;
			pos_2   <= input_defs_pkg::dial_reset_pos;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (step_en) begin
				// Pad request or held key moves the dial
				pos_1 <= next_pos(pos_1, left_req_1 | key_left_1, right_req_1 | key_right_1);
				pos_2 <= next_pos(pos_2, left_req_2 | key_left_2, right_req_2 | key_right_2);
			end
		end
	end

	// Game core only knows 12 dial positions
	a_dial_range: assert property (
		@(posedge clk_53p6) disable iff (reset)
		(pos_1 <= input_defs_pkg::dial_last_pos) && (pos_2 <= input_defs_pkg::dial_last_pos)
	) else $error("dial position out of range");

endmodule

// ==== logic/rotary_key_decoder.sv ====
/*
 * Rotate key decoder
 * Turns keyboard scan events into four held rotate flags
 */

`timescale 1ns/1ps

module rotary_key_decoder (
	input  logic        clk_53p6,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  logic        kbd_mode,
	output logic        left_1,
	output logic        right_1,
	output logic        left_2,
	output logic        right_2
);

	// Scan word fields
	localparam int key_toggle_bit  = 10;
	localparam int key_pressed_bit = 9;

	// Input stage
	logic       toggle_q;
	logic       pressed_q;
	logic [7:0] code_q;
	// Toggle seen last cycle
	logic       toggle_prev;
	logic       key_event;

	// Registered scan word and previous toggle
	always_ff @(posedge clk_53p6) begin
		toggle_q    <= ps2_key[key_toggle_bit];
		pressed_q   <= ps2_key[key_pressed_bit];
		code_q      <= ps2_key[7:0];
		toggle_prev <= toggle_q;
	end

	// New scan event on any toggle change
	assign key_event = (toggle_q != toggle_prev);

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			left_1  <= 1'b0;
			right_1 <= 1'b0;
			left_2  <= 1'b0;
			right_2 <= 1'b0;
		end else if (key_event) begin
			if (kbd_mode) begin
				// Flag follows make or break of its key
				case (code_q)
					input_defs_pkg::key_p1_left:  left_1  <= pressed_q;
					input_defs_pkg::key_p1_right: right_1 <= pressed_q;
					input_defs_pkg::key_p2_left:  left_2  <= pressed_q;
					input_defs_pkg::key_p2_right: right_2 <= pressed_q;
					default: ;
				endcase
			end else begin
				// Any event drops all keys outside keyboard mode
				left_1  <= 1'b0;
				right_1 <= 1'b0;
				left_2  <= 1'b0;
				right_2 <= 1'b0;
			end
		end
	end

endmodule

// ==== player_input_top.f ====
logic/input_defs_pkg.sv
logic/config_defs_pkg.sv
logic/input_config_regs.sv
logic/rotary_key_decoder.sv
logic/control_mapper.sv
logic/rotary_dial.sv
logic/player_input_top.sv
testbench/tb_player_input.sv

// ==== testbench/tb_player_input.sv ====
/*
 * Player input testbench
 * Reference model of settings, dial and key flags, with concurrent checks
 */

`timescale 1ns/1ps

module tb_player_input;

	localparam int div_bits = 8;
	// Test lengths in clock cycles
	localparam int reset_cycles = 8;
	localparam int map_cycles   = 300;
	localparam int dial_steps   = 14;
	localparam int dial_cycles  = 2 * dial_steps * (256 + 128 + 64 + 32);
	localparam int key_hold     = dial_steps * 32;
	localparam int kbd_cycles   = 2 * key_hold + 340;
	localparam int dip_cycles   = 20;
	localparam int total_cycles = reset_cycles + 2 * map_cycles + dial_cycles + kbd_cycles
		+ dip_cycles;
	localparam int watchdog_ns  = total_cycles * 8 * 3 / 2;

	logic        clk_53p6;
	logic        reset;
	logic [31:0] status;
	logic [10:0] ps2_key;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [15:0] db15_1;
	logic [15:0] db15_2;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [15:0] player1;
	logic [15:0] player2;
	logic [7:0]  dsw1;
	logic [7:0]  dsw2;
	logic [7:0]  game_id;

	// Reference model state
	logic        m_src1;
	logic        m_src2;
	logic        m_kbd;
	logic [1:0]  m_speed;
	logic [7:0]  m_div;
	logic        m_step;
	logic [3:0]  m_pos1;
	logic [3:0]  m_pos2;
	// Key flags: p1 left, p1 right, p2 left, p2 right
	logic [3:0]  m_flags;
	logic        tog_d1;
	logic        tog_d2;
	logic        pressed_d1;
	logic [7:0]  code_d1;
	logic [7:0]  m_dsw1;
	logic [7:0]  m_dsw2;
	logic [7:0]  m_game;
	logic [15:0] exp_player1;
	logic [15:0] exp_player2;
	logic [31:0] rng;
	int          err_count;
	int          test_count;
	int          failed_tests;

	player_input_top #(
		.ROT_DIV_BITS (div_bits)
	) dut_i (
		.clk_53p6    (clk_53p6),
		.reset       (reset),
		.status      (status),
		.ps2_key     (ps2_key),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.db15_1      (db15_1),
		.db15_2      (db15_2),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.player1     (player1),
		.player2     (player2),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game_id     (game_id)
	);

	initial begin
		clk_53p6 = 1'b0;
		forever #4 clk_53p6 = ~clk_53p6;
	end

	// =====================================================================
	// Reference helpers
	// =====================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Divider bits that must be zero for a step
	function automatic int step_bits(input logic [1:0] speed, input logic kbd);
		int k;
		case (speed)
			2'd1:    k = div_bits;
			2'd2:    k = div_bits - 2;
			2'd3:    k = div_bits - 3;
			default: k = div_bits - 1;
		endcase
		if (kbd)
			k = div_bits - 3;
		return k;
	endfunction

	function automatic logic [3:0] dial_step(input logic [3:0] pos, input logic l, input logic r);
		logic [3:0] nxt;
		nxt = pos;
		if (l)
			nxt = (pos == 4'd11) ? 4'd0 : pos + 4'd1;
		else if (r)
			nxt = (pos == 4'd0) ? 4'd11 : pos - 4'd1;
		return nxt;
	endfunction

	// Game core word, controls active low
	function automatic logic [15:0] expected_word(input logic src, input logic [15:0] joy,
		input logic [15:0] db, input logic [3:0] pos);
		logic [15:0] w;
		w = 16'h0000;
		w[15] = 1'b1;
		w[14] = 1'b1;
		w[8] = 1'b1;
		w[7:4] = pos;
		if (src) begin
			w[13] = ~db[3];
			w[12] = ~db[2];
			w[10] = ~db[1];
			w[11] = ~db[0];
			w[2] = ~db[5];
			w[3] = ~db[6];
			w[1] = ~db[10];
			w[0] = ~db[11];
			w[9] = ~(db[5] & db[11]);
		end else begin
			w[13] = ~joy[3];
			w[12] = ~joy[2];
			w[10] = ~joy[1];
			w[11] = ~joy[0];
			w[2] = ~joy[4];
			w[3] = ~joy[5];
			w[1] = ~joy[6];
			w[0] = ~joy[7];
			w[9] = ~joy[10];
		end
		return w;
	endfunction

	// =====================================================================
	// Reference model
	// =====================================================================
	assign m_step = ((int'(m_div) % (1 << step_bits(m_speed, m_kbd))) == 0);
	assign exp_player1 = expected_word(m_src1, joystick_0, db15_1, m_pos1);
	assign exp_player2 = expected_word(m_src2, joystick_1, db15_2, m_pos2);

	always_ff @(posedge clk_53p6) begin
		// Scan word seen two edges late
		tog_d1     <= ps2_key[10];
		pressed_d1 <= ps2_key[9];
		code_d1    <= ps2_key[7:0];
		tog_d2     <= tog_d1;
		if (reset) begin
			m_src1  <= 1'b0;
			m_src2  <= 1'b0;
			m_kbd   <= 1'b0;
			m_speed <= 2'd0;
			m_div   <= 8'd0;
			m_pos1  <= 4'd11;
			m_pos2  <= 4'd11;
			m_flags <= 4'b0000;
			m_dsw1  <= 8'hFF;
			m_dsw2  <= 8'hFF;
			m_game  <= 8'h00;
		end else begin
			m_src1  <= status[20];
			m_src2  <= status[21];
			m_kbd   <= status[24];
			m_speed <= status[30:29];
			m_div   <= m_div + 8'd1;
			if (m_step) begin
				m_pos1 <= dial_step(m_pos1, (m_src1 ? db15_1[4] : joystick_0[8]) | m_flags[0],
					(m_src1 ? db15_1[7] : joystick_0[9]) | m_flags[1]);
				m_pos2 <= dial_step(m_pos2, (m_src2 ? db15_2[4] : joystick_1[8]) | m_flags[2],
					(m_src2 ? db15_2[7] : joystick_1[9]) | m_flags[3]);
			end
			if (tog_d1 != tog_d2) begin
				if (!m_kbd)
					m_flags <= 4'b0000;
				else if (code_d1 == 8'h6B)
					m_flags[0] <= pressed_d1;
				else if (code_d1 == 8'h74)
					m_flags[1] <= pressed_d1;
				else if (code_d1 == 8'h21)
					m_flags[2] <= pressed_d1;
				else if (code_d1 == 8'h2A)
					m_flags[3] <= pressed_d1;
			end
			// Download capture
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd0)
				m_dsw1 <= ioctl_dout;
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd1)
				m_dsw2 <= ioctl_dout;
			if (ioctl_wr && ioctl_index == 8'd1 && ioctl_addr == 25'd0)
				m_game <= ioctl_dout;
		end
	end

	// =====================================================================
	// Checks
	// =====================================================================
	a_reset_values: assert property (@(posedge clk_53p6) $fell(reset) |->
		(player1 == 16'hFFBF && player2 == 16'hFFBF && dsw1 == 8'hFF && dsw2 == 8'hFF
		&& game_id == 8'h00))
		else begin
			$display("** Error at %0t: outputs not at reset values", $time);
			err_count++;
		end

	a_player1_word: assert property (@(posedge clk_53p6) disable iff (reset)
		player1 == exp_player1)
		else begin
			$display("** Error at %0t: player1 %h, expected %h", $time,
				$sampled(player1), $sampled(exp_player1));
			err_count++;
		end

	a_player2_word: assert property (@(posedge clk_53p6) disable iff (reset)
		player2 == exp_player2)
		else begin
			$display("** Error at %0t: player2 %h, expected %h", $time,
				$sampled(player2), $sampled(exp_player2));
			err_count++;
		end

	a_dip_bytes: assert property (@(posedge clk_53p6) disable iff (reset)
		dsw1 == m_dsw1 && dsw2 == m_dsw2 && game_id == m_game)
		else begin
			$display("** Error at %0t: dip/game %h %h %h, expected %h %h %h", $time,
				$sampled(dsw1), $sampled(dsw2), $sampled(game_id),
				$sampled(m_dsw1), $sampled(m_dsw2), $sampled(m_game));
			err_count++;
		end

	// =====================================================================
	// Stimulus
	// =====================================================================
	task automatic wait_cycle();
		@(posedge clk_53p6);
		#1;
	endtask

	task automatic apply_settings(input logic src1, input logic src2, input logic kbd,
		input logic [1:0] speed);
		status = 32'd0;
		status[20] = src1;
		status[21] = src2;
		status[24] = kbd;
		status[30:29] = speed;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		wait_cycle();
	endtask

	task automatic dl_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data, input logic strobe);
		ioctl_wr    = strobe;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		wait_cycle();
		ioctl_wr = 1'b0;
		wait_cycle();
	endtask

	// Random pads and DB15 words on both players
	task automatic drive_random_pads(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			rng = xorshift32(rng);
			joystick_0 = rng[15:0];
			joystick_1 = rng[31:16];
			rng = xorshift32(rng);
			db15_1 = rng[15:0];
			db15_2 = rng[31:16];
			wait_cycle();
		end
	endtask

	// Player 1 turns one way, player 2 the other
	task automatic hold_dial(input logic [1:0] speed, input logic p1_left);
		int cycles;
		cycles = dial_steps << step_bits(speed, 1'b0);
		apply_settings(1'b0, 1'b0, 1'b0, speed);
		for (int i = 0; i < cycles; i++) begin
			rng = xorshift32(rng);
			joystick_0 = (rng[15:0] & 16'hFCFF) | (p1_left ? 16'h0100 : 16'h0200);
			joystick_1 = (rng[31:16] & 16'hFCFF) | (p1_left ? 16'h0200 : 16'h0100);
			wait_cycle();
		end
	endtask

	task automatic rotate_by_keys();
		apply_settings(1'b0, 1'b0, 1'b1, 2'd0);
		joystick_0 = 16'h0000;
		joystick_1 = 16'h0000;
		repeat (2) wait_cycle();
		send_key(8'h6B, 1'b1);
		send_key(8'h2A, 1'b1);
		repeat (key_hold) wait_cycle();
		send_key(8'h6B, 1'b0);
		send_key(8'h2A, 1'b0);
		send_key(8'h74, 1'b1);
		send_key(8'h21, 1'b1);
		repeat (key_hold) wait_cycle();
		// Keys still held, mode off, then any event clears them
		apply_settings(1'b0, 1'b0, 1'b0, 2'd3);
		repeat (4) wait_cycle();
		send_key(8'h1C, 1'b1);
		repeat (300) wait_cycle();
	endtask

	task automatic load_dip_bytes();
		dl_write(8'd254, 25'd0, 8'hA5, 1'b1);
		dl_write(8'd254, 25'd1, 8'h3C, 1'b1);
		dl_write(8'd1, 25'd0, 8'h07, 1'b1);
		// None of these may land
		dl_write(8'd253, 25'd0, 8'h11, 1'b1);
		dl_write(8'd254, 25'd2, 8'h22, 1'b1);
		dl_write(8'd1, 25'd1, 8'h33, 1'b1);
		dl_write(8'd0, 25'd0, 8'h44, 1'b1);
		dl_write(8'd254, 25'd0, 8'h5A, 1'b0);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %s done, no errors", name);
		end else begin
			failed_tests++;
			$display("test %s done, %0d errors", name, err_count - errs_before);
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired, tests did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int errs;
		reset = 1'b1;
		status = 32'd0;
		ps2_key = 11'd0;
		joystick_0 = 16'h0000;
		joystick_1 = 16'h0000;
		db15_1 = 16'h0000;
		db15_2 = 16'h0000;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = 25'd0;
		ioctl_dout = 8'd0;
		rng = 32'd31837;
		err_count = 0;
		test_count = 0;
		failed_tests = 0;
		repeat (reset_cycles) wait_cycle();
		reset = 1'b0;
		errs = err_count;
		wait_cycle();
		finish_test("reset_values", errs);
		errs = err_count;
		drive_random_pads(map_cycles);
		finish_test("usb_mapping", errs);
		errs = err_count;
		apply_settings(1'b1, 1'b1, 1'b0, 2'd0);
		drive_random_pads(map_cycles);
		finish_test("db15_mapping", errs);
		errs = err_count;
		for (int s = 0; s < 4; s++) begin
			hold_dial(s[1:0], 1'b1);
			hold_dial(s[1:0], 1'b0);
		end
		finish_test("dial_stepping", errs);
		errs = err_count;
		rotate_by_keys();
		finish_test("keyboard_rotation", errs);
		errs = err_count;
		load_dip_bytes();
		finish_test("dip_game_capture", errs);
		$display("tests run %0d, tests failed %0d, check errors %0d",
			test_count, failed_tests, err_count);
		if (err_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
